// ==== logic/dmem_params.svh ====
/*
 * sizing macros for the block data memory subsystem
 * word and block widths, block address width, memory depth,
 * memory delay counter width and request queue depth
 */

`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// one data word
`define DWORD_SIZE_BITS 32

// a block is a group of words moved as one unit
`define DBLOCK_SIZE_WORDS 4
`define DBLOCK_SIZE_BITS 128

// block address, counted in blocks and not in bytes
`define DMEM_BLOCK_ADDR_SIZE 4
`define DMEM_SIZE_BLOCKS 16

// latency of the slow memory is 2**width cycles
`define DMEM_DELAY_CNTR_SIZE 2

// entries in the request queue between assembler and sequencer
`define REQ_FIFO_DEPTH 4

`endif

// ==== logic/req_pkg.sv ====
/*
 * request types shared along the request path
 * mem_op_t tells a block read from a block write
 */

`default_nettype none

package req_pkg;

	// opcode carried with every queued request
	// one bit is enough, there are only two kinds
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_t;

endpackage

`default_nettype wire

// ==== logic/ctrl_pkg.sv ====
/*
 * state types of the control FSMs
 * asm_state_t for the block assembler
 * seq_state_t for the memory sequencer
 */

`default_nettype none

package ctrl_pkg;

	// assembler is either waiting for a first word or filling a block
	typedef enum logic
	{
		ASM_IDLE = 1'b0,
		ASM_FILL = 1'b1
	} asm_state_t;

	// sequencer holds one memory level at a time, then rests a cycle
	typedef enum logic [1:0]
	{
		SEQ_IDLE  = 2'd0,
		SEQ_READ  = 2'd1,
		SEQ_WRITE = 2'd2,
		SEQ_GAP   = 2'd3
	} seq_state_t;

endpackage

`default_nettype wire

// ==== logic/block_assembler.sv ====
/*
 * block assembler, producer side of the request path
 * packs a burst of write words into one block request
 * turns a read strobe into a block read request
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module block_assembler
	import req_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              wr_strobe,
	input  logic                              rd_strobe,
	input  logic [`DWORD_SIZE_BITS-1:0]       word_data,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  block_address,
	output logic                              push,
	output mem_op_t                           push_op,
	output logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  push_address,
	output logic [`DBLOCK_SIZE_BITS-1:0]      push_block
);

	localparam int WCNT_BITS = $clog2(`DBLOCK_SIZE_WORDS);
	localparam logic [WCNT_BITS-1:0] LAST_WORD = WCNT_BITS'(`DBLOCK_SIZE_WORDS - 1);

	asm_state_t state;
	// index of the next word slot in the block
	logic [WCNT_BITS-1:0] word_cnt;
	// block address taken from the first word of a burst
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] fill_address;

	// control part, push is a one-cycle pulse
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= ASM_IDLE;
			word_cnt <= '0;
			push <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (wr_strobe)
			begin
				if (word_cnt == LAST_WORD)
				begin
					// block complete, hand it to the queue
					state <= ASM_IDLE;
					word_cnt <= '0;
					push <= 1'b1;
				end
				else
				begin
					state <= ASM_FILL;
					word_cnt <= word_cnt + 1'b1;
				end
			end
			// a read goes out at once, even in the middle of a fill
			if (rd_strobe)
				push <= 1'b1;
		end
	end

	// payload part, the block register fills in place
	always_ff @(posedge clock)
	begin
		if (wr_strobe)
		begin
			// first word lands in the lowest slot
			push_block[word_cnt*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS] <= word_data;
			if (state == ASM_IDLE)
				fill_address <= block_address;
		end
		if (rd_strobe)
		begin
			push_op <= OP_READ;
			push_address <= block_address;
		end
		else if (wr_strobe && word_cnt == LAST_WORD)
		begin
			push_op <= OP_WRITE;
			push_address <= fill_address;
		end
	end

endmodule

`default_nettype wire

// ==== logic/request_fifo.sv ====
/*
 * request queue between assembler and sequencer
 * circular buffer with show-ahead head outputs,
 * occupancy count, empty and full flags
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module request_fifo
	import req_pkg::*;
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              push,
	input  mem_op_t                           push_op,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  push_address,
	input  logic [`DBLOCK_SIZE_BITS-1:0]      push_block,
	input  logic                              pop,
	output mem_op_t                           head_op,
	output logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  head_address,
	output logic [`DBLOCK_SIZE_BITS-1:0]      head_block,
	output logic                              empty,
	output logic                              fifo_full
);

	localparam int PTR_BITS = $clog2(`REQ_FIFO_DEPTH);
	localparam int CNT_BITS = $clog2(`REQ_FIFO_DEPTH + 1);

	// entry storage, one array per field
	mem_op_t op_mem [0:`REQ_FIFO_DEPTH-1];
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] addr_mem [0:`REQ_FIFO_DEPTH-1];
	logic [`DBLOCK_SIZE_BITS-1:0] block_mem [0:`REQ_FIFO_DEPTH-1];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic do_push;
	logic do_pop;

	// wrap at the last entry, depth need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
		if (p == PTR_BITS'(`REQ_FIFO_DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	// a push into a full queue is dropped
	assign do_push = push && !fifo_full;
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign fifo_full = (count == CNT_BITS'(`REQ_FIFO_DEPTH));

	// show-ahead, head is the oldest entry
	assign head_op = op_mem[rd_ptr];
	assign head_address = addr_mem[rd_ptr];
	assign head_block = block_mem[rd_ptr];

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_push)
		begin
			op_mem[wr_ptr] <= push_op;
			addr_mem[wr_ptr] <= push_address;
			block_mem[wr_ptr] <= push_block;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_sequencer.sv ====
/*
 * memory sequencer, consumer side of the request queue
 * pops one request, holds ren or wen with address and data
 * until the memory answers, then rests one cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module mem_sequencer
	import req_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              empty,
	input  mem_op_t                           head_op,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  head_address,
	input  logic [`DBLOCK_SIZE_BITS-1:0]      head_block,
	input  logic                              ready,
	input  logic                              done,
	output logic                              pop,
	output logic                              ren,
	output logic                              wen,
	output logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  address,
	output logic [`DBLOCK_SIZE_BITS-1:0]      din
);

	seq_state_t state;

	// take the head while idle, the queue advances on the same edge
	assign pop = (state == SEQ_IDLE) && !empty;

	// levels follow the state
	// the answer cycle drops them so ready and done last one cycle
	assign ren = (state == SEQ_READ) && !ready;
	assign wen = (state == SEQ_WRITE) && !done;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= SEQ_IDLE;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (!empty)
					begin
						if (head_op == OP_READ)
							state <= SEQ_READ;
						else
							state <= SEQ_WRITE;
					end
				end
				SEQ_READ:
				begin
					if (ready)
						state <= SEQ_GAP;
				end
				SEQ_WRITE:
				begin
					if (done)
						state <= SEQ_GAP;
				end
				// one quiet cycle lets the memory clear its delay counter
				SEQ_GAP:
				begin
					state <= SEQ_IDLE;
				end
				default:
				begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// request fields held steady for the whole access
	always_ff @(posedge clock)
	begin
		if (pop)
		begin
			address <= head_address;
			din <= head_block;
		end
	end

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
/*
 * slow block data memory
 * word array organised as blocks, saturating delay counter,
 * write buffer captured at the start of a write,
 * registered ready, done and read data
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module data_memory
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              ren,
	input  logic                              wen,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  address,
	input  logic [`DBLOCK_SIZE_BITS-1:0]      din,
	output logic                              ready,
	output logic                              done,
	output logic [`DBLOCK_SIZE_BITS-1:0]      dout
);

	// storage, block by block, word 0 is the lowest word of a block
	logic [`DWORD_SIZE_BITS-1:0] mem [0:`DMEM_SIZE_BLOCKS-1][0:`DBLOCK_SIZE_WORDS-1];

	logic [`DMEM_DELAY_CNTR_SIZE-1:0] delay_cnt;
	logic delayed;
	logic cnt_clear;
	logic ready_next;
	logic done_next;
	// set once the write data has been taken
	logic captured;
	logic [`DBLOCK_SIZE_BITS-1:0] write_buf;

	// counter only runs while exactly one level is up
	assign cnt_clear = ~(ren ^ wen);
	assign delayed = &delay_cnt;

	assign ready_next = delayed && ren && !wen;
	assign done_next = delayed && wen && !ren;

	// counter saturates, ready and done then stay up with the level
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			delay_cnt <= '0;
			ready <= 1'b0;
			done <= 1'b0;
			captured <= 1'b0;
		end
		else
		begin
			if (cnt_clear)
				delay_cnt <= '0;
			else if (!delayed)
				delay_cnt <= delay_cnt + 1'b1;
			ready <= ready_next;
			done <= done_next;
			if (!wen || ren)
				captured <= 1'b0;
			else
				captured <= 1'b1;
		end
	end

	// write data taken on the first cycle of the level
	always_ff @(posedge clock)
	begin
		if (wen && !ren && !captured)
			write_buf <= din;
	end

	// block lands in the array when the delay runs out
	// a read registers its data together with ready
	always_ff @(posedge clock)
	begin
		if (done_next)
		begin
			for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
				mem[address][i] <= write_buf[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS];
		end
		if (ready_next)
		begin
			for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
				dout[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS] <= mem[address][i];
		end
	end

endmodule

`default_nettype wire

// ==== logic/dmem_subsystem.sv ====
/*
 * top level of the block data memory subsystem
 * assembler feeds the request queue, the sequencer drains it
 * into the slow data memory
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module dmem_subsystem
	import req_pkg::*;
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              wr_strobe,
	input  logic                              rd_strobe,
	input  logic [`DWORD_SIZE_BITS-1:0]       word_data,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0]  block_address,
	output logic                              fifo_full,
	output logic                              rsp_valid,
	output logic [`DBLOCK_SIZE_BITS-1:0]      rsp_data,
	output logic                              wr_done
);

	// assembler to queue
	logic push;
	mem_op_t push_op;
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] push_address;
	logic [`DBLOCK_SIZE_BITS-1:0] push_block;

	// queue head to sequencer
	logic pop;
	logic empty;
	mem_op_t head_op;
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] head_address;
	logic [`DBLOCK_SIZE_BITS-1:0] head_block;

	// sequencer to memory
	logic ren;
	logic wen;
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] mem_address;
	logic [`DBLOCK_SIZE_BITS-1:0] mem_din;

	block_assembler i_block_assembler (.clock(clock), .reset(reset),
		.wr_strobe(wr_strobe), .rd_strobe(rd_strobe),
		.word_data(word_data), .block_address(block_address),
		.push(push), .push_op(push_op),
		.push_address(push_address), .push_block(push_block));

	request_fifo i_request_fifo (.clock(clock), .reset(reset),
		.push(push), .push_op(push_op),
		.push_address(push_address), .push_block(push_block), .pop(pop),
		.head_op(head_op), .head_address(head_address), .head_block(head_block),
		.empty(empty), .fifo_full(fifo_full));

	// memory ready and done double as the response strobes
	mem_sequencer i_mem_sequencer (.clock(clock), .reset(reset),
		.empty(empty), .head_op(head_op),
		.head_address(head_address), .head_block(head_block),
		.ready(rsp_valid), .done(wr_done), .pop(pop), .ren(ren), .wen(wen),
		.address(mem_address), .din(mem_din));

	data_memory i_data_memory (.clock(clock), .reset(reset),
		.ren(ren), .wen(wen), .address(mem_address), .din(mem_din),
		.ready(rsp_valid), .done(wr_done), .dout(rsp_data));

endmodule

`default_nettype wire

// ==== testbench/dmem_assert.sv ====
/*
 * concurrent protocol checks bound into dmem_subsystem
 * memory levels, response pulses, strobes under back-pressure,
 * read latency and the sequencer rest cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module dmem_assert
	import ctrl_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        wr_strobe,
	input  logic        rd_strobe,
	input  logic        fifo_full,
	input  logic        ren,
	input  logic        wen,
	input  logic        rsp_valid,
	input  logic        wr_done,
	input  seq_state_t  seq_state
);

	localparam int LATENCY = 1 << `DMEM_DELAY_CNTR_SIZE;

	// cycles ren has been sampled high in a row
	int ren_held;

	// protocol failures so far
	int fail_cnt = 0;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			ren_held <= 0;
		else if (ren)
			ren_held <= ren_held + 1;
		else
			ren_held <= 0;
	end

	// responses and full flag quiet once reset lets go
	a_quiet_after_reset: assert property (@(posedge clock)
		$rose(reset) |-> !rsp_valid && !wr_done && !fifo_full)
		else
		begin
			$error("response or full flag high right after reset");
			fail_cnt++;
		end

	a_levels_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(ren && wen))
		else
		begin
			$error("ren and wen high together");
			fail_cnt++;
		end

	// sequencer drops the level on the answer, so each answer is one cycle
	a_rsp_one_cycle: assert property (@(posedge clock) disable iff (!reset)
		rsp_valid |=> !rsp_valid)
		else
		begin
			$error("rsp_valid longer than one cycle");
			fail_cnt++;
		end

	a_done_one_cycle: assert property (@(posedge clock) disable iff (!reset)
		wr_done |=> !wr_done)
		else
		begin
			$error("wr_done longer than one cycle");
			fail_cnt++;
		end

	// a strobe into a full queue would be lost
	a_no_strobe_when_full: assert property (@(posedge clock) disable iff (!reset)
		fifo_full |-> !(wr_strobe || rd_strobe))
		else
		begin
			$error("strobe while fifo_full is high");
			fail_cnt++;
		end

	a_read_latency: assert property (@(posedge clock) disable iff (!reset)
		$rose(rsp_valid) |-> ren_held >= LATENCY)
		else
		begin
			$error("ready rose before ren was held for the memory latency");
			fail_cnt++;
		end

	// the cycle after any answer the sequencer rests
	a_gap_after_answer: assert property (@(posedge clock) disable iff (!reset)
		(rsp_valid || wr_done) |=> seq_state == SEQ_GAP)
		else
		begin
			$error("sequencer skipped its rest cycle after an answer");
			fail_cnt++;
		end

endmodule

// attach to every dmem_subsystem instance
bind dmem_subsystem dmem_assert i_dmem_assert
(
	.clock(clock),
	.reset(reset),
	.wr_strobe(wr_strobe),
	.rd_strobe(rd_strobe),
	.fifo_full(fifo_full),
	.ren(ren),
	.wen(wen),
	.rsp_valid(rsp_valid),
	.wr_done(wr_done),
	.seq_state(i_mem_sequencer.state)
);

`default_nettype wire

// ==== testbench/dmem_tb.sv ====
/*
 * testbench for the block data memory subsystem
 * clock and reset, strobe stimulus, block reference model,
 * response checks and a watchdog
 */

`timescale 1ns/1ns
`default_nettype none

`include "dmem_params.svh"

module dmem_tb;

	localparam int NUM_WRITES = 11;
	localparam int NUM_READS = 17;
	// a strobe takes about three cycles with the spacing in send_strobe
	localparam int NUM_STROBES = NUM_WRITES * `DBLOCK_SIZE_WORDS + NUM_READS;
	localparam int WATCHDOG_CYCLES = 8 + 4 * NUM_STROBES + 50 * (NUM_WRITES + NUM_READS);

	logic clock;
	logic reset;
	logic wr_strobe;
	logic rd_strobe;
	logic [`DWORD_SIZE_BITS-1:0] word_data;
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] block_address;
	logic fifo_full;
	logic rsp_valid;
	logic [`DBLOCK_SIZE_BITS-1:0] rsp_data;
	logic wr_done;

	// reference model, blocks as written and reads still outstanding
	logic [`DBLOCK_SIZE_BITS-1:0] model_mem [0:`DMEM_SIZE_BLOCKS-1];
	logic [`DBLOCK_SIZE_BITS-1:0] exp_q [$];

	integer seed;
	int errors;
	int writes_issued;
	int reads_issued;
	int done_cnt;
	int rsp_cnt;
	logic saw_full;
	logic [`DBLOCK_SIZE_BITS-1:0] blk;

	dmem_subsystem i_dmem_subsystem (.clock(clock), .reset(reset),
		.wr_strobe(wr_strobe), .rd_strobe(rd_strobe),
		.word_data(word_data), .block_address(block_address),
		.fifo_full(fifo_full), .rsp_valid(rsp_valid),
		.rsp_data(rsp_data), .wr_done(wr_done));

	always #10 clock = ~clock;

	task automatic check_value(input string name, input logic [`DBLOCK_SIZE_BITS-1:0] got,
		input logic [`DBLOCK_SIZE_BITS-1:0] expected);
		assert (got === expected)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, got);
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		assert (got == expected)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, got);
		end
	endtask

	function automatic logic [`DBLOCK_SIZE_BITS-1:0] random_block();
		logic [`DBLOCK_SIZE_BITS-1:0] b;
		for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
			b[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS] = $random(seed);
		return b;
	endfunction

	// one strobe, only once the previous push has landed and the queue has room
	task automatic send_strobe(input logic is_write,
		input logic [`DMEM_BLOCK_ADDR_SIZE-1:0] addr, input logic [`DWORD_SIZE_BITS-1:0] data);
		@(negedge clock);
		@(negedge clock);
		while (fifo_full)
			@(negedge clock);
		@(posedge clock);
		wr_strobe <= is_write;
		rd_strobe <= !is_write;
		block_address <= addr;
		word_data <= data;
		@(posedge clock);
		wr_strobe <= 1'b0;
		rd_strobe <= 1'b0;
	endtask

	task automatic write_block(input logic [`DMEM_BLOCK_ADDR_SIZE-1:0] addr,
		input logic [`DBLOCK_SIZE_BITS-1:0] data);
		for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
			send_strobe(1'b1, addr, data[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS]);
		// the last word fixes the place of the write in request order
		model_mem[addr] = data;
		writes_issued++;
	endtask

	task automatic read_block(input logic [`DMEM_BLOCK_ADDR_SIZE-1:0] addr);
		exp_q.push_back(model_mem[addr]);
		reads_issued++;
		send_strobe(1'b0, addr, '0);
	endtask

	// responses come back in request order
	always @(negedge clock)
	begin
		if (reset && rsp_valid)
		begin
			rsp_cnt++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("error at %0t: read response arrived with no read outstanding", $time);
			end
			else
				check_value("rsp_data", rsp_data, exp_q.pop_front());
		end
		if (reset && wr_done)
			done_cnt++;
		if (fifo_full)
			saw_full = 1'b1;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("error: watchdog ran out after %0d cycles with requests still open",
			WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'hcea29806;
		clock = 1'b0;
		reset = 1'b0;
		wr_strobe = 1'b0;
		rd_strobe = 1'b0;
		word_data = '0;
		block_address = '0;
		saw_full = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		check_count("rsp_valid", int'(rsp_valid), 0);
		check_count("wr_done", int'(wr_done), 0);
		check_count("fifo_full", int'(fifo_full), 0);

		// single block round trip
		write_block(4'd3, random_block());
		read_block(4'd3);

		// several blocks, read back out of order
		for (int i = 0; i < 4; i++)
			write_block(4'(5 + i), random_block());
		read_block(4'd8);
		read_block(4'd5);
		read_block(4'd7);
		read_block(4'd6);

		// writes then a run of reads faster than the memory drains them
		for (int i = 0; i < 5; i++)
			write_block(4'(10 + i), random_block());
		for (int i = 0; i < 5; i++)
			read_block(4'(14 - i));
		for (int i = 0; i < 5; i++)
			read_block(4'(10 + i));

		// read overtakes a half-built write
		blk = random_block();
		for (int i = 0; i < 2; i++)
			send_strobe(1'b1, 4'd9, blk[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS]);
		read_block(4'd5);
		for (int i = 2; i < `DBLOCK_SIZE_WORDS; i++)
			send_strobe(1'b1, 4'd9, blk[i*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS]);
		model_mem[9] = blk;
		writes_issued++;
		read_block(4'd9);

		// drain, the watchdog bounds this
		while (exp_q.size() != 0 || done_cnt != writes_issued)
			@(posedge clock);
		repeat (10) @(posedge clock);
		check_count("wr_done pulses", done_cnt, writes_issued);
		check_count("rsp_valid pulses", rsp_cnt, reads_issued);
		if (!saw_full)
		begin
			errors++;
			$display("error: fifo_full never went high during the read run");
		end
		// bound protocol checks that fired count against the run
		errors += i_dmem_subsystem.i_dmem_assert.fail_cnt;
		$display("errors %0d, reads %0d of %0d answered, writes %0d of %0d done",
			errors, rsp_cnt, reads_issued, done_cnt, writes_issued);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/req_pkg.sv
logic/ctrl_pkg.sv
logic/block_assembler.sv
logic/request_fifo.sv
logic/mem_sequencer.sv
logic/data_memory.sv
logic/dmem_subsystem.sv
testbench/dmem_assert.sv
testbench/dmem_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the testbench with Verilator, run it, then look for the pass line
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module dmem_tb \
	-f all.f \
	-o dmem_sim

./obj_dir/dmem_sim 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log
then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation failed, see sim.log"
	exit 1
fi
